/* test/csr_stim.txt */
# write: bank reg data | read: bank reg expected | gpio: input expected_gpio_o (all hex)
# wait: cycles | irq: bit window expect_pulse | reset: window (all decimal)
# System id, back-to-back reads and an unmapped bank
read 1 3 11004d31
read 5 0 0
read 2 0 0
# GPIO output register and input-change interrupt
write 1 1 3
write 1 2 7f
gpio 00 3
read 1 1 3
read 1 2 7f
read 1 3 11004d31
gpio 15 3
irq 0 3 1
read 1 0 15
write 1 2 0
gpio 2a 3
irq 0 8 0
write 1 2 1
gpio 2b 3
irq 0 3 1
gpio 0b 3
irq 0 8 0
read 1 0 0b
# One-shot timer, then autorestart
write 2 1 5
write 2 0 1
irq 1 9 1
read 2 0 0
read 2 1 5
write 2 1 3
write 2 0 3
irq 1 7 1
irq 1 7 1
write 2 0 0
write 2 2 1234
read 2 2 1234
read 2 0 0
wait 3
# Hard reset clears the GPIO outputs
write 1 4 1
reset 6
read 1 1 0
gpio 00 0

/* compile.f */
verilog/csr_pkg.sv
verilog/reset_sequencer.sv
verilog/csr_decode.sv
verilog/sysctl_bank.sv
verilog/timer_bank.sv
verilog/csr_result.sv
verilog/csr_system.sv
test/tb_clock_gen.sv
test/tb_csr_system.sv

/* Makefile */
TOP = tb_csr_system
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f -o $(TOP)

# The log decides pass or fail
run: build
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

lint:
	verilator --lint-only --timing --top-module csr_system -f compile.f

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_csr_system.sv */
// Testbench top with stim file reader, CSR master, read scoreboard, interrupt checks, timeout
module tb_csr_system;

	typedef logic [63:0] word_t;

	localparam string STIM_FILE = "test/csr_stim.txt";

	logic               sys_clk;
	logic               trigger_reset;
	logic               csr_stb_i;
	logic               csr_we_i;
	csr_pkg::csr_addr_t csr_a_i;
	csr_pkg::csr_data_t csr_dw_i;
	csr_pkg::csr_data_t csr_dr_o;
	logic               csr_rvalid_o;
	csr_pkg::gpio_in_t  gpio_i;
	csr_pkg::gpio_out_t gpio_o;
	logic [1:0]         irq_o;
	logic               sys_rst_o;
	logic               flash_rst_n_o;

	// Outstanding reads, oldest first
	csr_pkg::csr_data_t exp_q[$];
	csr_pkg::csr_addr_t addr_q[$];
	int                 issue_q[$];
	int                 cycle_count = 0;
	int                 cycle_limit = 0;

	tb_clock_gen u_clock_gen (
		.sys_clk_o       (sys_clk),
		.trigger_reset_o (trigger_reset)
	);

	csr_system dut (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.csr_stb_i     (csr_stb_i),
		.csr_we_i      (csr_we_i),
		.csr_a_i       (csr_a_i),
		.csr_dw_i      (csr_dw_i),
		.csr_dr_o      (csr_dr_o),
		.csr_rvalid_o  (csr_rvalid_o),
		.gpio_i        (gpio_i),
		.gpio_o        (gpio_o),
		.irq_o         (irq_o),
		.sys_rst_o     (sys_rst_o),
		.flash_rst_n_o (flash_rst_n_o)
	);

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic void stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "Run stopped at the first failure");
	endfunction

	function automatic void check_operands(input int got, input int want, input word_t name);
		assert (got == want) else
			stop_with_failure($sformatf("Stim line %0s has %0d operands, expected %0d",
				name, got, want));
	endfunction

	// Bus idle for one cycle
	task automatic idle_cycle();
		@(posedge sys_clk);
		csr_stb_i <= 1'b0;
		csr_we_i  <= 1'b0;
	endtask

	// One strobe, reads also queue their expected word
	task automatic bus_access(input logic write, input csr_pkg::bank_t bank,
			input logic [9:0] regnum, input csr_pkg::csr_data_t data);
		@(posedge sys_clk);
		csr_stb_i <= 1'b1;
		csr_we_i  <= write;
		csr_a_i   <= {bank, regnum};
		csr_dw_i  <= write ? data : '0;
		if (!write) begin
			exp_q.push_back(data);
			addr_q.push_back({bank, regnum});
		end
	endtask

	task automatic apply_gpio(input csr_pkg::gpio_in_t value, input csr_pkg::gpio_out_t out_exp);
		idle_cycle();
		gpio_i <= value;
		@(negedge sys_clk);
		assert (gpio_o === out_exp) else
			stop_with_failure($sformatf("** Error at %0t: gpio_o is %h, expected %h",
				$time, gpio_o, out_exp));
	endtask

	// Pulse must show up within the window and last one cycle, or stay absent
	task automatic expect_irq(input logic irq_bit, input int window, input bit want_pulse);
		int waited;
		bit seen;
		waited = 0;
		seen   = 1'b0;
		idle_cycle();
		while (!seen && waited < window) begin
			@(negedge sys_clk);
			waited++;
			seen = irq_o[irq_bit] === 1'b1;
		end
		if (want_pulse) begin
			assert (seen) else
				stop_with_failure($sformatf("No pulse on irq_o[%0d] within %0d cycles",
					irq_bit, window));
			@(negedge sys_clk);
			assert (irq_o[irq_bit] === 1'b0) else
				stop_with_failure($sformatf("Pulse on irq_o[%0d] lasted more than one cycle",
					irq_bit));
		end else begin
			assert (!seen) else
				stop_with_failure($sformatf("Unexpected pulse on irq_o[%0d]", irq_bit));
		end
	endtask

	// System reset must rise, then stay high for the debounce length once
	// its source is gone, with flash leaving reset first
	task automatic check_reset_sequence(input int window);
		int waited;
		int high_cycles;
		bit flash_low_seen;
		bit flash_high_seen;
		waited          = 0;
		high_cycles     = 0;
		flash_low_seen  = 1'b0;
		flash_high_seen = 1'b0;
		do begin
			@(negedge sys_clk);
			waited++;
		end while (sys_rst_o !== 1'b1 && waited < window);
		assert (sys_rst_o === 1'b1) else
			stop_with_failure($sformatf("System reset did not rise within %0d cycles", window));
		while (sys_rst_o === 1'b1) begin
			if (trigger_reset === 1'b0) begin
				high_cycles++;
				if (flash_rst_n_o === 1'b1) begin
					flash_high_seen = 1'b1;
				end else begin
					flash_low_seen = 1'b1;
				end
			end
			@(negedge sys_clk);
		end
		assert (high_cycles == int'(csr_pkg::RST_DEBOUNCE_CYCLES)) else
			stop_with_failure($sformatf("** Error at %0t: system reset held %0d cycles, expected %0d",
				$time, high_cycles, csr_pkg::RST_DEBOUNCE_CYCLES));
		assert (flash_low_seen && flash_high_seen && flash_rst_n_o === 1'b1) else
			stop_with_failure("Flash reset was not released before the system reset");
	endtask

	// ------------------------------
	// Read scoreboard
	// ------------------------------
	// Outputs sampled on the falling edge
	always @(negedge sys_clk) begin
		if (csr_rvalid_o === 1'b1) begin
			assert (issue_q.size() > 0 && exp_q.size() > 0) else
				stop_with_failure("Read data valid came with no read outstanding");
			assert (cycle_count - issue_q[0] == csr_pkg::READ_LATENCY) else
				stop_with_failure($sformatf("** Error at %0t: read latency %0d, expected %0d",
					$time, cycle_count - issue_q[0], csr_pkg::READ_LATENCY));
			assert (csr_dr_o === exp_q[0]) else
				stop_with_failure($sformatf("** Error at %0t: read of %h returned %h, expected %h",
					$time, addr_q[0], csr_dr_o, exp_q[0]));
			void'(issue_q.pop_front());
			void'(exp_q.pop_front());
			void'(addr_q.pop_front());
		end else if (issue_q.size() > 0) begin
			assert (cycle_count - issue_q[0] <= csr_pkg::READ_LATENCY) else
				stop_with_failure("A read strobe got no read data valid");
		end
		// Strobe seen here is taken at the next rising edge
		if (csr_stb_i === 1'b1 && csr_we_i === 1'b0 && sys_rst_o === 1'b0) begin
			issue_q.push_back(cycle_count);
		end
	end

	// Cycle counter and timeout
	always @(posedge sys_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			stop_with_failure($sformatf("Timeout, run did not finish within %0d cycles",
				cycle_limit));
		end
	end

	// ------------------------------
	// Stim file runner
	// ------------------------------
	initial begin
		int                 fd;
		int                 line_count;
		int                 n;
		int                 count;
		int                 want_pulse;
		word_t              cmd;
		logic [8*160-1:0]   line;
		csr_pkg::bank_t     bank;
		logic [9:0]         regnum;
		csr_pkg::csr_data_t data;
		csr_pkg::gpio_in_t  gpio_val;
		csr_pkg::gpio_out_t gpio_exp;
		logic               irq_bit;

		csr_stb_i = 1'b0;
		csr_we_i  = 1'b0;
		csr_a_i   = '0;
		csr_dw_i  = '0;
		gpio_i    = '0;

		// Limit grows with the stim length
		line_count = 0;
		fd = $fopen(STIM_FILE, "r");
		assert (fd != 0) else
			stop_with_failure("Could not open the stim file test/csr_stim.txt");
		while ($fgets(line, fd) != 0) begin
			line_count++;
		end
		$fclose(fd);
		cycle_limit = 600 + 64 * line_count;

		// Power-on reset
		check_reset_sequence(4);
		assert (gpio_o === '0 && irq_o === '0 && csr_rvalid_o === 1'b0) else
			stop_with_failure($sformatf("** Error at %0t: outputs not idle after reset", $time));

		fd = $fopen(STIM_FILE, "r");
		while ($fscanf(fd, "%s", cmd) == 1) begin
			case (cmd)
				word_t'("#"): n = $fgets(line, fd);
				word_t'("write"): begin
					n = $fscanf(fd, "%h %h %h", bank, regnum, data);
					check_operands(n, 3, cmd);
					bus_access(1'b1, bank, regnum, data);
				end
				word_t'("read"): begin
					n = $fscanf(fd, "%h %h %h", bank, regnum, data);
					check_operands(n, 3, cmd);
					bus_access(1'b0, bank, regnum, data);
				end
				word_t'("gpio"): begin
					n = $fscanf(fd, "%h %h", gpio_val, gpio_exp);
					check_operands(n, 2, cmd);
					apply_gpio(gpio_val, gpio_exp);
				end
				word_t'("wait"): begin
					n = $fscanf(fd, "%d", count);
					check_operands(n, 1, cmd);
					repeat (count) idle_cycle();
				end
				word_t'("irq"): begin
					n = $fscanf(fd, "%d %d %d", irq_bit, count, want_pulse);
					check_operands(n, 3, cmd);
					expect_irq(irq_bit, count, want_pulse != 0);
				end
				word_t'("reset"): begin
					n = $fscanf(fd, "%d", count);
					check_operands(n, 1, cmd);
					idle_cycle();
					check_reset_sequence(count);
				end
				default: stop_with_failure($sformatf("Unknown stim command %0s", cmd));
			endcase
		end
		$fclose(fd);

		// Drain reads still in flight
		idle_cycle();
		while (exp_q.size() > 0) begin
			@(negedge sys_clk);
		end
		$display("Verification passed");
		$finish;
	end

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock generator and power-on reset
module tb_clock_gen (
	output logic sys_clk_o,
	output logic trigger_reset_o
);

	// Period of 40 time units
	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 10;

	initial begin
		sys_clk_o = 1'b0;
		forever begin
			#HALF_PERIOD sys_clk_o = ~sys_clk_o;
		end
	end

	// High from time zero, dropped on a rising edge
	initial begin
		trigger_reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge sys_clk_o);
		trigger_reset_o <= 1'b0;
	end

endmodule

/* verilog/csr_system.sv */
// Top level wiring of reset sequencer, CSR decode, register banks and read combining
module csr_system (
	input  logic               sys_clk,
	input  logic               trigger_reset,

	// CSR bus
	input  logic               csr_stb_i,
	input  logic               csr_we_i,
	input  csr_pkg::csr_addr_t csr_a_i,
	input  csr_pkg::csr_data_t csr_dw_i,
	output csr_pkg::csr_data_t csr_dr_o,
	output logic               csr_rvalid_o,

	// GPIO
	input  csr_pkg::gpio_in_t  gpio_i,
	output csr_pkg::gpio_out_t gpio_o,

	// Bit 0 GPIO, bit 1 timer
	output logic [1:0]         irq_o,

	output logic               sys_rst_o,
	output logic               flash_rst_n_o
);

	logic               hard_reset;
	logic               sel_sysctl;
	logic               sel_timer;
	logic [9:0]         csr_reg;
	logic               csr_we;
	logic               rd_issue;
	csr_pkg::csr_data_t dr_sysctl;
	csr_pkg::csr_data_t dr_timer;

	// ------------------------------
	// Reset
	// ------------------------------
	reset_sequencer u_reset_sequencer (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.hard_reset_i  (hard_reset),
		.sys_rst_o     (sys_rst_o),
		.flash_rst_n_o (flash_rst_n_o)
	);

	// ------------------------------
	// Decode
	// ------------------------------
	csr_decode u_csr_decode (
		.csr_stb_i    (csr_stb_i),
		.csr_we_i     (csr_we_i),
		.csr_a_i      (csr_a_i),
		.sys_rst_i    (sys_rst_o),
		.sel_sysctl_o (sel_sysctl),
		.sel_timer_o  (sel_timer),
		.reg_o        (csr_reg),
		.we_o         (csr_we),
		.rd_issue_o   (rd_issue)
	);

	// ------------------------------
	// Register banks
	// ------------------------------
	sysctl_bank u_sysctl_bank (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst_o),
		.sel_i        (sel_sysctl),
		.we_i         (csr_we),
		.reg_i        (csr_reg),
		.dw_i         (csr_dw_i),
		.dr_o         (dr_sysctl),
		.gpio_i       (gpio_i),
		.gpio_o       (gpio_o),
		.irq_o        (irq_o[0]),
		.hard_reset_o (hard_reset)
	);

	timer_bank u_timer_bank (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst_o),
		.sel_i     (sel_timer),
		.we_i      (csr_we),
		.reg_i     (csr_reg),
		.dw_i      (csr_dw_i),
		.dr_o      (dr_timer),
		.irq_o     (irq_o[1])
	);

	// Read data back to the master
	csr_result u_csr_result (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst_o),
		.rd_issue_i   (rd_issue),
		.dr_sysctl_i  (dr_sysctl),
		.dr_timer_i   (dr_timer),
		.csr_dr_o     (csr_dr_o),
		.csr_rvalid_o (csr_rvalid_o)
	);

endmodule

/* verilog/csr_result.sv */
// CSR read-data combining with registered data and valid strobe
module csr_result (
	input  logic               sys_clk,
	input  logic               sys_rst_i,
	input  logic               rd_issue_i,
	input  csr_pkg::csr_data_t dr_sysctl_i,
	input  csr_pkg::csr_data_t dr_timer_i,
	output csr_pkg::csr_data_t csr_dr_o,
	output logic               csr_rvalid_o
);

	// Read flag lined up with the bank words
	logic rd_issue_q;

	// ------------------------------
	// Valid pipeline
	// ------------------------------
	// Two stages from strobe to valid, matching the bank latency plus one
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			rd_issue_q   <= 1'b0;
			csr_rvalid_o <= 1'b0;
		end else begin
			rd_issue_q   <= rd_issue_i;
			csr_rvalid_o <= rd_issue_q;
		end
	end

	// ------------------------------
	// Data combining
	// ------------------------------
	// Idle banks hold zero, so a plain OR picks the one that answered
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= dr_sysctl_i | dr_timer_i;
	end

endmodule

/* verilog/timer_bank.sv */
// Timer bank with control, compare and counter registers and match interrupt
module timer_bank (
	input  logic               sys_clk,
	input  logic               sys_rst_i,
	input  logic               sel_i,
	input  logic               we_i,
	input  logic [9:0]         reg_i,
	input  csr_pkg::csr_data_t dw_i,
	output csr_pkg::csr_data_t dr_o,
	output logic               irq_o
);

	// Control bits
	logic               en;
	logic               autorestart;
	csr_pkg::csr_data_t compare;
	csr_pkg::csr_data_t counter;
	logic               match;

	// Only a running timer can match
	assign match = en & (counter == compare);

	// ------------------------------
	// Counter and control
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			en          <= 1'b0;
			autorestart <= 1'b0;
			counter     <= '0;
			irq_o       <= 1'b0;
		end else begin
			irq_o <= match;
			if (match) begin
				// Wrap to zero, one-shot mode stops here
				counter <= '0;
				en      <= autorestart;
			end else if (en) begin
				counter <= counter + csr_pkg::csr_data_t'(1);
			end

			// Bus writes win over counting in the same cycle
			if (sel_i & we_i) begin
				case (reg_i)
					csr_pkg::TIMER_CTRL: begin
						en          <= dw_i[0];
						autorestart <= dw_i[1];
						// Fresh start from zero on enable
						if (dw_i[0]) begin
							counter <= '0;
						end
					end
					csr_pkg::TIMER_COUNTER: counter <= dw_i;
					default: ;
				endcase
			end
		end
	end

	// Compare value is plain data
	always_ff @(posedge sys_clk) begin
		if (sel_i & we_i & (reg_i == csr_pkg::TIMER_COMPARE)) begin
			compare <= dw_i;
		end
	end

	// ------------------------------
	// Read word
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		dr_o <= '0;
		if (sel_i & ~we_i) begin
			case (reg_i)
				csr_pkg::TIMER_CTRL:    dr_o <= {30'd0, autorestart, en};
				csr_pkg::TIMER_COMPARE: dr_o <= compare;
				csr_pkg::TIMER_COUNTER: dr_o <= counter;
				default:                dr_o <= '0;
			endcase
		end
	end

endmodule

/* verilog/sysctl_bank.sv */
// System controller bank with GPIO, input-change interrupt, system id and hard reset
module sysctl_bank (
	input  logic                sys_clk,
	input  logic                sys_rst_i,
	input  logic                sel_i,
	input  logic                we_i,
	input  logic [9:0]          reg_i,
	input  csr_pkg::csr_data_t  dw_i,
	output csr_pkg::csr_data_t  dr_o,
	input  csr_pkg::gpio_in_t   gpio_i,
	output csr_pkg::gpio_out_t  gpio_o,
	output logic                irq_o,
	output logic                hard_reset_o
);

	// Input sample and its previous value for edge detection
	csr_pkg::gpio_in_t gpio_in_q;
	csr_pkg::gpio_in_t gpio_in_prev;
	// Per-input interrupt enable
	csr_pkg::gpio_in_t gpio_irqen;
	csr_pkg::gpio_in_t gpio_change;

	// ------------------------------
	// GPIO inputs
	// ------------------------------
	// Registered once, then compared against the last sample
	always_ff @(posedge sys_clk) begin
		gpio_in_q    <= gpio_i;
		gpio_in_prev <= gpio_in_q;
	end

	assign gpio_change = (gpio_in_q ^ gpio_in_prev) & gpio_irqen;

	// One pulse per enabled change
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			irq_o <= 1'b0;
		end else begin
			irq_o <= |gpio_change;
		end
	end

	// ------------------------------
	// Register writes
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_o       <= '0;
			gpio_irqen   <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			// Request lasts a single cycle
			hard_reset_o <= 1'b0;
			if (sel_i & we_i) begin
				case (reg_i)
					csr_pkg::SYSCTL_GPIO_OUT:   gpio_o <= dw_i[1:0];
					csr_pkg::SYSCTL_GPIO_IRQEN: gpio_irqen <= dw_i[6:0];
					// Feeds back into the reset sequencer
					csr_pkg::SYSCTL_HARD_RESET: hard_reset_o <= dw_i[0];
					default: ;
				endcase
			end
		end
	end

	// ------------------------------
	// Read word
	// ------------------------------
	// Zero unless this bank was read in the previous cycle
	always_ff @(posedge sys_clk) begin
		dr_o <= '0;
		if (sel_i & ~we_i) begin
			case (reg_i)
				csr_pkg::SYSCTL_GPIO_IN:    dr_o <= csr_pkg::csr_data_t'(gpio_in_q);
				csr_pkg::SYSCTL_GPIO_OUT:   dr_o <= csr_pkg::csr_data_t'(gpio_o);
				csr_pkg::SYSCTL_GPIO_IRQEN: dr_o <= csr_pkg::csr_data_t'(gpio_irqen);
				csr_pkg::SYSCTL_SYSID:      dr_o <= csr_pkg::SYSTEM_ID;
				// Hard reset reads as zero, like unused slots
				default:                    dr_o <= '0;
			endcase
		end
	end

endmodule

/* verilog/csr_decode.sv */
// CSR bank selection and read-issue flag
module csr_decode (
	input  logic               csr_stb_i,
	input  logic               csr_we_i,
	input  csr_pkg::csr_addr_t csr_a_i,
	input  logic               sys_rst_i,
	output logic               sel_sysctl_o,
	output logic               sel_timer_o,
	output logic [9:0]         reg_o,
	output logic               we_o,
	output logic               rd_issue_o
);

	logic           stb_ok;
	csr_pkg::bank_t bank;

	// No access gets through while the system is held in reset
	assign stb_ok = csr_stb_i & ~sys_rst_i;

	// Bank field is the top nibble of the address
	assign bank  = csr_a_i[13:10];
	assign reg_o = csr_a_i[9:0];

	// ------------------------------
	// Per-bank selects
	// ------------------------------
	assign sel_sysctl_o = stb_ok & (bank == csr_pkg::BANK_SYSCTL);
	assign sel_timer_o  = stb_ok & (bank == csr_pkg::BANK_TIMER);

	// Write qualifier shared by all banks
	assign we_o = stb_ok & csr_we_i;

	// Every read is flagged, even to an empty bank
	// Unmapped banks then return the zero OR of all words
	assign rd_issue_o = stb_ok & ~csr_we_i;

endmodule

/* verilog/reset_sequencer.sv */
// Reset sequencer with debounce counter and early flash reset release
module reset_sequencer (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic hard_reset_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	// Either source restarts the whole sequence
	logic                restart;
	csr_pkg::rst_count_t rst_debounce;
	csr_pkg::rst_count_t flash_count;

	assign restart = trigger_reset | hard_reset_i;

	// ------------------------------
	// System reset
	// ------------------------------
	// Reload while the source is held, then count down to zero
	always_ff @(posedge sys_clk) begin
		if (restart) begin
			rst_debounce <= csr_pkg::RST_DEBOUNCE_CYCLES;
		end else if (rst_debounce != '0) begin
			rst_debounce <= rst_debounce - csr_pkg::rst_count_t'(1);
		end
	end

	// Held for as long as the counter runs
	assign sys_rst_o = rst_debounce != '0;

	// ------------------------------
	// Flash reset
	// ------------------------------
	// Counts up from the same restart and stops at the release point
	always_ff @(posedge sys_clk) begin
		if (restart) begin
			flash_count <= '0;
		end else if (flash_count != csr_pkg::FLASH_RST_CYCLES) begin
			flash_count <= flash_count + csr_pkg::rst_count_t'(1);
		end
	end

	// Shorter count, so flash is out of reset before the system
	assign flash_rst_n_o = flash_count == csr_pkg::FLASH_RST_CYCLES;

endmodule

/* verilog/csr_pkg.sv */
// CSR widths, bank and register numbers, reset lengths and system id
package csr_pkg;

	// ------------------------------
	// Bus widths
	// ------------------------------
	// Upper 4 bits pick the bank, lower 10 the register
	typedef logic [13:0] csr_addr_t;
	typedef logic [31:0] csr_data_t;
	typedef logic [3:0]  bank_t;

	// Banks on the CSR bus
	localparam bank_t BANK_SYSCTL = 4'd1;
	localparam bank_t BANK_TIMER  = 4'd2;

	// System controller registers
	localparam logic [9:0] SYSCTL_GPIO_IN     = 10'd0;
	localparam logic [9:0] SYSCTL_GPIO_OUT    = 10'd1;
	localparam logic [9:0] SYSCTL_GPIO_IRQEN  = 10'd2;
	localparam logic [9:0] SYSCTL_SYSID       = 10'd3;
	localparam logic [9:0] SYSCTL_HARD_RESET  = 10'd4;

	// Timer registers
	localparam logic [9:0] TIMER_CTRL    = 10'd0;
	localparam logic [9:0] TIMER_COMPARE = 10'd1;
	localparam logic [9:0] TIMER_COUNTER = 10'd2;

	// ------------------------------
	// GPIO and identification
	// ------------------------------
	typedef logic [6:0] gpio_in_t;
	typedef logic [1:0] gpio_out_t;

	// Board revision word
	localparam csr_data_t SYSTEM_ID = 32'h11004D31;

	// Reset sequencing, flash comes out well before the system
	typedef logic [8:0] rst_count_t;
	localparam rst_count_t RST_DEBOUNCE_CYCLES = 9'd256;
	localparam rst_count_t FLASH_RST_CYCLES    = 9'd128;

	// Cycles from read strobe to read data
	localparam int READ_LATENCY = 2;

endpackage
